// ==== logic/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // core and memory bus widths
    localparam int ADDR_W     = 16;
    localparam int MEM_ADDR_W = 12;
    localparam int WORD_W     = 32;
    localparam int BEAT_W     = 128;

    // cache geometry
    localparam int LINE_BYTES = 64;
    localparam int BEATS      = 4;
    localparam int BEAT_IDX_W = 2;
    localparam int SETS       = 8;
    localparam int WAYS       = 2;
    localparam int IDX_W      = 3;
    localparam int WAY_W      = 1;

    // address fields are tag [15:9], set index [8:6], line offset [5:0]
    localparam int TAG_W      = 7;
    localparam int OFS_W      = 6;

    // top bit set means zero extension on loads
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        BYTE_U = 3'b100,
        HALF_U = 3'b101
    } mem_dtype_t;

    typedef enum logic [1:0] {
        RESET,
        READY,
        MISS,
        EVICT
    } dcache_state_t;

endpackage

`default_nettype wire

// ==== logic/dcache_load_align.sv ====
`default_nettype none

module dcache_load_align (
    input  wire  [dcache_pkg::WORD_W-1:0] rd_word,
    input  wire  dcache_pkg::mem_dtype_t  rd_dtype,
    input  wire  [1:0]                    rd_offset,
    output logic [dcache_pkg::WORD_W-1:0] rsp_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        sext;

    assign byte_sel = rd_word[rd_offset*8 +: 8];
    // odd offsets are misaligned, so only the upper offset bit picks the half
    assign half_sel = rd_word[{rd_offset[1], 4'b0000} +: 16];
    assign sext     = !rd_dtype[2];

    always_comb begin
        rsp_data = '0;
        case (rd_dtype)
            dcache_pkg::BYTE, dcache_pkg::BYTE_U: begin
                rsp_data = {{24{byte_sel[7] & sext}}, byte_sel};
            end
            dcache_pkg::HALF, dcache_pkg::HALF_U: begin
                if (!rd_offset[0]) begin
                    rsp_data = {{16{half_sel[15] & sext}}, half_sel};
                end
            end
            dcache_pkg::WORD: begin
                if (rd_offset == 2'b00) begin
                    rsp_data = rd_word;
                end
            end
            default: rsp_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/dcache_lru.sv ====
`default_nettype none

module dcache_lru (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [dcache_pkg::ADDR_W-1:0] lookup_addr,
    input  wire                           lru_touch,
    input  wire  [dcache_pkg::WAY_W-1:0]  lru_way,
    input  wire  [dcache_pkg::IDX_W-1:0]  lru_set,
    output logic [dcache_pkg::WAY_W-1:0]  victim_way
);

    // age 0 is most recent, ages in a set are always a permutation
    logic [dcache_pkg::WAY_W-1:0] age [dcache_pkg::WAYS][dcache_pkg::SETS];
    logic [dcache_pkg::IDX_W-1:0] idx;

    assign idx = lookup_addr[dcache_pkg::OFS_W +: dcache_pkg::IDX_W];

    always_comb begin
        victim_way = '0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (&age[w][idx]) begin
                victim_way = w[dcache_pkg::WAY_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                for (int s = 0; s < dcache_pkg::SETS; s++) begin
                    age[w][s] <= w[dcache_pkg::WAY_W-1:0];
                end
            end
        end else if (lru_touch) begin
            // ways younger than the touched one get one step older
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                if (age[w][lru_set] < age[lru_way][lru_set]) begin
                    age[w][lru_set] <= age[w][lru_set] + 1'b1;
                end
            end
            age[lru_way][lru_set] <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dcache_tag_store.sv ====
`default_nettype none

module dcache_tag_store (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [dcache_pkg::ADDR_W-1:0] lookup_addr,
    input  wire                           fill_done,
    input  wire  [dcache_pkg::WAY_W-1:0]  fill_way,
    input  wire  [dcache_pkg::TAG_W-1:0]  fill_tag,
    input  wire                           store_en,
    input  wire  [dcache_pkg::WAY_W-1:0]  store_way,
    input  wire  [dcache_pkg::ADDR_W-1:0] store_addr,
    input  wire  [dcache_pkg::WAY_W-1:0]  victim_way,
    output logic                          hit,
    output logic [dcache_pkg::WAY_W-1:0]  hit_way,
    output logic                          victim_dirty,
    output logic [dcache_pkg::TAG_W-1:0]  victim_tag
);

    logic                         valid [dcache_pkg::WAYS][dcache_pkg::SETS];
    logic                         dirty [dcache_pkg::WAYS][dcache_pkg::SETS];
    logic [dcache_pkg::TAG_W-1:0] tag   [dcache_pkg::WAYS][dcache_pkg::SETS];

    logic [dcache_pkg::IDX_W-1:0] idx;
    logic [dcache_pkg::IDX_W-1:0] store_idx;

    assign idx       = lookup_addr[dcache_pkg::OFS_W +: dcache_pkg::IDX_W];
    assign store_idx = store_addr[dcache_pkg::OFS_W +: dcache_pkg::IDX_W];

    // compare all ways of the set in parallel
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (valid[w][idx]
                && (tag[w][idx] == lookup_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W])) begin
                hit     = 1'b1;
                hit_way = w[dcache_pkg::WAY_W-1:0];
            end
        end
        victim_dirty = dirty[victim_way][idx];
        victim_tag   = tag[victim_way][idx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                for (int s = 0; s < dcache_pkg::SETS; s++) begin
                    valid[w][s] <= 1'b0;
                    dirty[w][s] <= 1'b0;
                end
            end
        end else if (fill_done) begin
            // freshly filled line matches memory
            valid[fill_way][idx] <= 1'b1;
            dirty[fill_way][idx] <= 1'b0;
        end else if (store_en) begin
            dirty[store_way][store_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag[fill_way][idx] <= fill_tag;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dcache_data_store.sv ====
`default_nettype none

module dcache_data_store (
    input  wire                               clk,
    input  wire                               fill_en,
    input  wire  [dcache_pkg::WAY_W-1:0]      fill_way,
    input  wire  [dcache_pkg::BEAT_IDX_W-1:0] fill_beat,
    input  wire  [dcache_pkg::ADDR_W-1:0]     lookup_addr,
    input  wire  [dcache_pkg::BEAT_W-1:0]     mem_rsp_data,
    input  wire                               store_en,
    input  wire  [dcache_pkg::WAY_W-1:0]      store_way,
    input  wire  [dcache_pkg::ADDR_W-1:0]     store_addr,
    input  wire  [dcache_pkg::WORD_W-1:0]     store_wdata,
    input  wire  dcache_pkg::mem_dtype_t      store_dtype,
    input  wire  [dcache_pkg::WAY_W-1:0]      rd_way,
    input  wire  [dcache_pkg::ADDR_W-1:0]     rd_addr,
    input  wire  [dcache_pkg::WAY_W-1:0]      evict_way,
    input  wire  [dcache_pkg::BEAT_IDX_W-1:0] evict_beat,
    output logic [dcache_pkg::WORD_W-1:0]     rd_word,
    output logic [dcache_pkg::BEAT_W-1:0]     evict_data
);

    logic [dcache_pkg::LINE_BYTES-1:0][7:0] line [dcache_pkg::WAYS][dcache_pkg::SETS];

    logic [dcache_pkg::IDX_W-1:0]    idx;
    logic [dcache_pkg::IDX_W-1:0]    store_idx;
    logic [dcache_pkg::IDX_W-1:0]    rd_idx;
    logic [dcache_pkg::WORD_W/8-1:0] store_mask;

    // fill and eviction both work on the set of the pending request
    assign idx       = lookup_addr[dcache_pkg::OFS_W +: dcache_pkg::IDX_W];
    assign store_idx = store_addr[dcache_pkg::OFS_W +: dcache_pkg::IDX_W];
    assign rd_idx    = rd_addr[dcache_pkg::OFS_W +: dcache_pkg::IDX_W];

    always_comb begin
        case (store_dtype)
            dcache_pkg::BYTE, dcache_pkg::BYTE_U: store_mask = 4'b0001;
            dcache_pkg::HALF, dcache_pkg::HALF_U: store_mask = 4'b0011;
            dcache_pkg::WORD:                     store_mask = 4'b1111;
            default:                              store_mask = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            line[fill_way][idx][fill_beat * (dcache_pkg::BEAT_W / 8) +: dcache_pkg::BEAT_W / 8]
                <= mem_rsp_data;
        end else if (store_en) begin
            for (int i = 0; i < dcache_pkg::WORD_W / 8; i++) begin
                if (store_mask[i]) begin
                    line[store_way][store_idx][store_addr[dcache_pkg::OFS_W-1:0]
                        + i[dcache_pkg::OFS_W-1:0]] <= store_wdata[i*8 +: 8];
                end
            end
        end
    end

    assign rd_word    = line[rd_way][rd_idx][{rd_addr[dcache_pkg::OFS_W-1:2], 2'b00}
                            +: dcache_pkg::WORD_W / 8];
    assign evict_data = line[evict_way][idx][evict_beat * (dcache_pkg::BEAT_W / 8)
                            +: dcache_pkg::BEAT_W / 8];

endmodule

`default_nettype wire

// ==== logic/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               req_valid,
    input  wire                               req_write,
    input  wire  [dcache_pkg::ADDR_W-1:0]     req_addr,
    input  wire  [dcache_pkg::WORD_W-1:0]     req_wdata,
    input  wire  dcache_pkg::mem_dtype_t      req_dtype,
    output logic                              req_ready,
    output logic                              rsp_valid,
    input  wire                               hit,
    input  wire  [dcache_pkg::WAY_W-1:0]      hit_way,
    input  wire  [dcache_pkg::WAY_W-1:0]      victim_way,
    input  wire                               victim_dirty,
    input  wire  [dcache_pkg::TAG_W-1:0]      victim_tag,
    input  wire                               mem_rsp_valid,
    output logic                              mem_rd_valid,
    output logic [dcache_pkg::MEM_ADDR_W-1:0] mem_rd_addr,
    output logic                              mem_wr_valid,
    output logic [dcache_pkg::MEM_ADDR_W-1:0] mem_wr_addr,
    output logic [dcache_pkg::ADDR_W-1:0]     lookup_addr,
    output logic                              fill_en,
    output logic [dcache_pkg::WAY_W-1:0]      fill_way,
    output logic [dcache_pkg::BEAT_IDX_W-1:0] fill_beat,
    output logic                              fill_done,
    output logic [dcache_pkg::TAG_W-1:0]      fill_tag,
    output logic                              store_en,
    output logic [dcache_pkg::WAY_W-1:0]      store_way,
    output logic [dcache_pkg::ADDR_W-1:0]     store_addr,
    output logic [dcache_pkg::WORD_W-1:0]     store_wdata,
    output dcache_pkg::mem_dtype_t            store_dtype,
    output logic [dcache_pkg::WAY_W-1:0]      rd_way,
    output logic [dcache_pkg::ADDR_W-1:0]     rd_addr,
    output dcache_pkg::mem_dtype_t            rd_dtype,
    output logic [dcache_pkg::WAY_W-1:0]      evict_way,
    output logic [dcache_pkg::BEAT_IDX_W-1:0] evict_beat,
    output logic                              lru_touch,
    output logic [dcache_pkg::WAY_W-1:0]      lru_way,
    output logic [dcache_pkg::IDX_W-1:0]      lru_set
);

    dcache_pkg::dcache_state_t state;
    dcache_pkg::dcache_state_t state_nx;

    // accepted request, looked up in the following cycle
    logic                          new_q;
    logic                          q_write;
    logic [dcache_pkg::ADDR_W-1:0] q_addr;
    logic [dcache_pkg::WORD_W-1:0] q_wdata;
    dcache_pkg::mem_dtype_t        q_dtype;

    // request parked while the line is evicted and refilled
    logic                          pend_active;
    logic                          pend_write;
    logic [dcache_pkg::ADDR_W-1:0] pend_addr;
    logic [dcache_pkg::WORD_W-1:0] pend_wdata;
    dcache_pkg::mem_dtype_t        pend_dtype;
    logic [dcache_pkg::WAY_W-1:0]  pend_way;
    logic [dcache_pkg::TAG_W-1:0]  pend_vtag;

    logic [dcache_pkg::BEAT_IDX_W-1:0] wr_cnt;
    logic [dcache_pkg::BEAT_IDX_W-1:0] rsp_cnt;
    // extra bit marks all read beats issued
    logic [dcache_pkg::BEAT_IDX_W:0]   rd_cnt;

    logic accept;
    logic hit_now;
    logic miss_now;
    logic serve_pend;

    assign accept     = req_valid && req_ready;
    assign hit_now    = (state == dcache_pkg::READY) && new_q && hit;
    assign miss_now   = (state == dcache_pkg::READY) && new_q && !hit;
    assign serve_pend = (state == dcache_pkg::READY) && pend_active;

    // ready drops in the cycle a miss is seen
    assign req_ready = (state == dcache_pkg::READY) && !miss_now;
    assign rsp_valid = (hit_now && !q_write) || (serve_pend && !pend_write);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= dcache_pkg::RESET;
            new_q       <= 1'b0;
            pend_active <= 1'b0;
            wr_cnt      <= '0;
            rd_cnt      <= '0;
            rsp_cnt     <= '0;
        end else begin
            state <= state_nx;
            new_q <= accept;
            if (miss_now) begin
                pend_active <= 1'b1;
            end else if (serve_pend) begin
                pend_active <= 1'b0;
            end
            if (mem_wr_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (fill_done) begin
                rd_cnt <= '0;
            end else if (mem_rd_valid) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (mem_rsp_valid) begin
                rsp_cnt <= rsp_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            q_write <= req_write;
            q_addr  <= req_addr;
            q_wdata <= req_wdata;
            q_dtype <= req_dtype;
        end
        if (miss_now) begin
            pend_write <= q_write;
            pend_addr  <= q_addr;
            pend_wdata <= q_wdata;
            pend_dtype <= q_dtype;
            pend_way   <= victim_way;
            pend_vtag  <= victim_tag;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            dcache_pkg::RESET: state_nx = dcache_pkg::READY;
            dcache_pkg::READY: begin
                if (miss_now && victim_dirty) begin
                    state_nx = dcache_pkg::EVICT;
                end else if (miss_now) begin
                    state_nx = dcache_pkg::MISS;
                end
            end
            dcache_pkg::EVICT: begin
                if (&wr_cnt) begin
                    state_nx = dcache_pkg::MISS;
                end
            end
            dcache_pkg::MISS: begin
                if (fill_done) begin
                    state_nx = dcache_pkg::READY;
                end
            end
            default: state_nx = dcache_pkg::RESET;
        endcase
    end

    // victim writeback, the last write beat also starts the refill
    assign mem_wr_valid = (state == dcache_pkg::EVICT);
    assign mem_wr_addr  = {pend_vtag, pend_addr[dcache_pkg::OFS_W +: dcache_pkg::IDX_W], wr_cnt};
    assign mem_rd_valid = (mem_wr_valid && &wr_cnt)
                       || ((state == dcache_pkg::MISS) && !rd_cnt[dcache_pkg::BEAT_IDX_W]);
    assign mem_rd_addr  = {pend_addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFS_W],
                           rd_cnt[dcache_pkg::BEAT_IDX_W-1:0]};
    assign evict_way    = pend_way;
    assign evict_beat   = wr_cnt;

    assign lookup_addr = pend_active ? pend_addr : q_addr;
    assign fill_en     = mem_rsp_valid;
    assign fill_way    = pend_way;
    assign fill_beat   = rsp_cnt;
    assign fill_done   = mem_rsp_valid && &rsp_cnt;
    assign fill_tag    = pend_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];

    // pending request wins over the registered one once the fill is done
    always_comb begin
        store_en  = (hit_now && q_write) || (serve_pend && pend_write);
        lru_touch = hit_now || serve_pend;
        if (serve_pend) begin
            store_way   = pend_way;
            store_addr  = pend_addr;
            store_wdata = pend_wdata;
            store_dtype = pend_dtype;
        end else begin
            store_way   = hit_way;
            store_addr  = q_addr;
            store_wdata = q_wdata;
            store_dtype = q_dtype;
        end
        rd_way   = store_way;
        rd_addr  = store_addr;
        rd_dtype = store_dtype;
        lru_way  = store_way;
        lru_set  = store_addr[dcache_pkg::OFS_W +: dcache_pkg::IDX_W];
    end

endmodule

`default_nettype wire

// ==== logic/dcache_top.sv ====
`default_nettype none

module dcache_top (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               req_valid,
    input  wire                               req_write,
    input  wire  [dcache_pkg::ADDR_W-1:0]     req_addr,
    input  wire  [dcache_pkg::WORD_W-1:0]     req_wdata,
    input  wire  dcache_pkg::mem_dtype_t      req_dtype,
    output logic                              req_ready,
    output logic                              rsp_valid,
    output logic [dcache_pkg::WORD_W-1:0]     rsp_data,
    output logic                              mem_rd_valid,
    output logic [dcache_pkg::MEM_ADDR_W-1:0] mem_rd_addr,
    output logic                              mem_wr_valid,
    output logic [dcache_pkg::MEM_ADDR_W-1:0] mem_wr_addr,
    output logic [dcache_pkg::BEAT_W-1:0]     mem_wr_data,
    input  wire                               mem_rsp_valid,
    input  wire  [dcache_pkg::BEAT_W-1:0]     mem_rsp_data
);

    logic                              hit;
    logic [dcache_pkg::WAY_W-1:0]      hit_way;
    logic [dcache_pkg::WAY_W-1:0]      victim_way;
    logic                              victim_dirty;
    logic [dcache_pkg::TAG_W-1:0]      victim_tag;
    logic [dcache_pkg::ADDR_W-1:0]     lookup_addr;
    logic                              fill_en;
    logic [dcache_pkg::WAY_W-1:0]      fill_way;
    logic [dcache_pkg::BEAT_IDX_W-1:0] fill_beat;
    logic                              fill_done;
    logic [dcache_pkg::TAG_W-1:0]      fill_tag;
    logic                              store_en;
    logic [dcache_pkg::WAY_W-1:0]      store_way;
    logic [dcache_pkg::ADDR_W-1:0]     store_addr;
    logic [dcache_pkg::WORD_W-1:0]     store_wdata;
    dcache_pkg::mem_dtype_t            store_dtype;
    logic [dcache_pkg::WAY_W-1:0]      rd_way;
    logic [dcache_pkg::ADDR_W-1:0]     rd_addr;
    dcache_pkg::mem_dtype_t            rd_dtype;
    logic [dcache_pkg::WORD_W-1:0]     rd_word;
    logic [dcache_pkg::WAY_W-1:0]      evict_way;
    logic [dcache_pkg::BEAT_IDX_W-1:0] evict_beat;
    logic                              lru_touch;
    logic [dcache_pkg::WAY_W-1:0]      lru_way;
    logic [dcache_pkg::IDX_W-1:0]      lru_set;

    dcache_ctrl i_ctrl (
        .clk, .rst,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_dtype,
        .req_ready, .rsp_valid,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .mem_rsp_valid,
        .mem_rd_valid, .mem_rd_addr, .mem_wr_valid, .mem_wr_addr,
        .lookup_addr,
        .fill_en, .fill_way, .fill_beat, .fill_done, .fill_tag,
        .store_en, .store_way, .store_addr, .store_wdata, .store_dtype,
        .rd_way, .rd_addr, .rd_dtype,
        .evict_way, .evict_beat,
        .lru_touch, .lru_way, .lru_set
    );

    dcache_tag_store i_tag_store (
        .clk, .rst,
        .lookup_addr,
        .fill_done, .fill_way, .fill_tag,
        .store_en, .store_way, .store_addr,
        .victim_way,
        .hit, .hit_way, .victim_dirty, .victim_tag
    );

    dcache_lru i_lru (
        .clk, .rst,
        .lookup_addr,
        .lru_touch, .lru_way, .lru_set,
        .victim_way
    );

    dcache_data_store i_data_store (
        .clk,
        .fill_en, .fill_way, .fill_beat,
        .lookup_addr, .mem_rsp_data,
        .store_en, .store_way, .store_addr, .store_wdata, .store_dtype,
        .rd_way, .rd_addr,
        .evict_way, .evict_beat,
        .rd_word,
        .evict_data (mem_wr_data)
    );

    dcache_load_align i_load_align (
        .rd_word,
        .rd_dtype,
        .rd_offset (rd_addr[1:0]),
        .rsp_data
    );

endmodule

`default_nettype wire

// ==== dv/dcache_mem_model.sv ====
`default_nettype none

module dcache_mem_model (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               mem_rd_valid,
    input  wire  [dcache_pkg::MEM_ADDR_W-1:0] mem_rd_addr,
    input  wire                               mem_wr_valid,
    input  wire  [dcache_pkg::MEM_ADDR_W-1:0] mem_wr_addr,
    input  wire  [dcache_pkg::BEAT_W-1:0]     mem_wr_data,
    output logic                              mem_rsp_valid,
    output logic [dcache_pkg::BEAT_W-1:0]     mem_rsp_data
);

    // one entry per 128-bit beat
    logic [dcache_pkg::BEAT_W-1:0] mem [1 << dcache_pkg::MEM_ADDR_W];

    // every word holds its own word address with a marker in the upper half
    function automatic logic [dcache_pkg::BEAT_W-1:0] init_beat(input int beat);
        logic [dcache_pkg::BEAT_W-1:0] data;
        data = '0;
        for (int w = 0; w < dcache_pkg::BEAT_W / dcache_pkg::WORD_W; w++) begin
            data[w*32 +: 32] = 32'(beat * 4 + w) ^ 32'ha5a50000;
        end
        return data;
    endfunction

    initial begin
        for (int b = 0; b < (1 << dcache_pkg::MEM_ADDR_W); b++) begin
            mem[b] <= init_beat(b);
        end
    end

    // reads answer one cycle later, writebacks land in the array
    always @(posedge clk) begin
        if (rst) begin
            mem_rsp_valid <= 1'b0;
        end else begin
            mem_rsp_valid <= mem_rd_valid;
        end
        if (mem_rd_valid) begin
            mem_rsp_data <= mem[mem_rd_addr];
        end
        if (mem_wr_valid) begin
            mem[mem_wr_addr] <= mem_wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_dcache.sv ====
`default_nettype none

module tb_dcache;

    logic                              clk;
    logic                              rst;
    logic                              req_valid;
    logic                              req_write;
    logic [dcache_pkg::ADDR_W-1:0]     req_addr;
    logic [dcache_pkg::WORD_W-1:0]     req_wdata;
    dcache_pkg::mem_dtype_t            req_dtype;
    logic                              req_ready;
    logic                              rsp_valid;
    logic [dcache_pkg::WORD_W-1:0]     rsp_data;
    logic                              mem_rd_valid;
    logic [dcache_pkg::MEM_ADDR_W-1:0] mem_rd_addr;
    logic                              mem_wr_valid;
    logic [dcache_pkg::MEM_ADDR_W-1:0] mem_wr_addr;
    logic [dcache_pkg::BEAT_W-1:0]     mem_wr_data;
    logic                              mem_rsp_valid;
    logic [dcache_pkg::BEAT_W-1:0]     mem_rsp_data;

    // op 0 is a store, 1 a load, 2 a load that must hit
    logic [1:0]                    case_op    [$];
    logic [dcache_pkg::ADDR_W-1:0] case_addr  [$];
    logic [2:0]                    case_type  [$];
    logic [dcache_pkg::WORD_W-1:0] case_wdata [$];
    logic [dcache_pkg::WORD_W-1:0] case_exp   [$];

    // loads in flight, oldest first
    int outstanding_case  [$];
    int outstanding_cycle [$];

    // last request driven and the beats seen so far in the current bursts
    int last_case;
    int rd_beat;
    int wr_beat;

    int n_cases;
    int errors;
    int checks;
    bit loaded;

    dcache_top i_dut (
        .clk, .rst,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_dtype,
        .req_ready, .rsp_valid, .rsp_data,
        .mem_rd_valid, .mem_rd_addr,
        .mem_wr_valid, .mem_wr_addr, .mem_wr_data,
        .mem_rsp_valid, .mem_rsp_data
    );

    dcache_mem_model i_mem (
        .clk, .rst,
        .mem_rd_valid, .mem_rd_addr,
        .mem_wr_valid, .mem_wr_addr, .mem_wr_data,
        .mem_rsp_valid, .mem_rsp_data
    );

    always #2 clk = ~clk;

    task automatic load_cases();
        int fd;
        string line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_type;
        logic [31:0] f_wdata;
        logic [31:0] f_exp;
        fd = $fopen("dv/dcache_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file dv/dcache_cases.txt");
            errors++;
        end else begin
            // comment and blank lines do not scan as five hex fields
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%h %h %h %h %h",
                            f_op, f_addr, f_type, f_wdata, f_exp) == 5) begin
                    case_op.push_back(f_op[1:0]);
                    case_addr.push_back(f_addr[dcache_pkg::ADDR_W-1:0]);
                    case_type.push_back(f_type[2:0]);
                    case_wdata.push_back(f_wdata);
                    case_exp.push_back(f_exp);
                end
            end
            $fclose(fd);
        end
        n_cases = case_op.size();
    endtask

    task automatic check_value(input int case_no, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR case %0d %s expected %h actual %h", case_no, what, expected, actual);
        end
    endtask

    initial begin
        int idx;
        int cycle;
        int case_no;
        int acc_cycle;
        bit done;
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_dtype = dcache_pkg::WORD;
        errors    = 0;
        checks    = 0;
        last_case = -1;
        rd_beat   = 0;
        wr_beat   = 0;
        load_cases();
        loaded = 1'b1;
        repeat (16) @(negedge clk);
        rst   = 1'b0;
        idx   = 0;
        cycle = 0;
        done  = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycle++;
            if (rsp_valid) begin
                if (outstanding_case.size() == 0) begin
                    $display("a load response arrived with no load outstanding");
                    errors++;
                end else begin
                    case_no   = outstanding_case.pop_front();
                    acc_cycle = outstanding_cycle.pop_front();
                    check_value(case_no, "data", case_exp[case_no], rsp_data);
                    if (case_op[case_no] == 2'd2) begin
                        check_value(case_no, "latency", 32'd1, 32'(cycle - acc_cycle));
                    end
                end
            end
            // ready only depends on registered state, so it is settled here
            if (req_ready && idx < n_cases) begin
                req_valid = 1'b1;
                req_write = (case_op[idx] == 2'd0);
                req_addr  = case_addr[idx];
                req_wdata = case_wdata[idx];
                req_dtype = dcache_pkg::mem_dtype_t'(case_type[idx]);
                if (case_op[idx] != 2'd0) begin
                    outstanding_case.push_back(idx);
                    outstanding_cycle.push_back(cycle);
                end
                last_case = idx;
                idx++;
            end else begin
                req_valid = 1'b0;
                done = (idx == n_cases) && req_ready && (outstanding_case.size() == 0);
            end
        end
        $display("cases %0d checks %0d errors %0d", n_cases, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // a refill reads the four beats of the missed line back to back, a writeback
    // covers four beats of the same set and its last beat starts the refill
    always @(negedge clk) begin
        if (!rst && last_case >= 0) begin
            if (mem_wr_valid) begin
                check_value(last_case, "writeback addr",
                            (32'(case_addr[last_case] >> dcache_pkg::OFS_W) % dcache_pkg::SETS)
                            * dcache_pkg::BEATS + wr_beat,
                            32'(mem_wr_addr) % (dcache_pkg::SETS * dcache_pkg::BEATS));
                check_value(last_case, "refill start", 32'(wr_beat == dcache_pkg::BEATS - 1),
                            32'(mem_rd_valid));
                wr_beat = (wr_beat + 1) % dcache_pkg::BEATS;
            end else if (wr_beat != 0) begin
                $display("the writeback for case %0d stopped after %0d beats", last_case, wr_beat);
                errors++;
                wr_beat = 0;
            end
            if (mem_rd_valid) begin
                check_value(last_case, "refill addr",
                            32'(case_addr[last_case] >> dcache_pkg::OFS_W) * dcache_pkg::BEATS
                            + rd_beat,
                            32'(mem_rd_addr));
                rd_beat = (rd_beat + 1) % dcache_pkg::BEATS;
            end else if (rd_beat != 0) begin
                $display("the refill for case %0d stopped after %0d beats", last_case, rd_beat);
                errors++;
                rd_beat = 0;
            end
        end
    end

    // generous budget of 64 cycles per case on top of reset
    initial begin
        wait (loaded);
        repeat (16 + (n_cases + 1) * 64) @(posedge clk);
        $display("timeout, the cache stopped answering before all cases completed");
        $display("cases %0d checks %0d errors %0d", n_cases, checks, errors + 1);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/dcache_cases.txt ====
# columns: op addr type wdata expected, all hex; op 0 store, 1 load, 2 load that must hit
# type: 0 byte, 1 half, 2 word, 4 byte unsigned, 5 half unsigned
# cold miss, then a hit in the same line
1 0100 2 00000000 a5a50040
2 0104 2 00000000 a5a50041
# masked stores that hit, read back
0 0109 0 12345677 00000000
2 0108 2 00000000 a5a57742
0 010e 1 deadbeef 00000000
2 010c 2 00000000 beef0043
0 0110 2 8081fe7f 00000000
2 0110 2 00000000 8081fe7f
# sign and zero extension, misaligned loads
2 0111 0 00000000 fffffffe
2 0111 4 00000000 000000fe
2 0110 0 00000000 0000007f
2 0112 1 00000000 ffff8081
2 0112 5 00000000 00008081
2 0110 1 00000000 fffffe7f
2 0111 1 00000000 00000000
2 0112 2 00000000 00000000
2 0113 4 00000000 00000080
# three lines in set 4, dirty evictions
1 0300 2 00000000 a5a500c0
0 0304 2 11223344 00000000
1 0500 2 00000000 a5a50140
1 0108 2 00000000 a5a57742
2 010c 2 00000000 beef0043
2 0110 2 00000000 8081fe7f
1 0304 2 00000000 11223344
# store miss allocates, then back-to-back hits
0 0842 1 0000beef 00000000
2 0840 2 00000000 beef0210
2 0844 2 00000000 a5a50211
2 0848 2 00000000 a5a50212

// ==== dcache.f ====
logic/dcache_pkg.sv
logic/dcache_load_align.sv
logic/dcache_lru.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/dcache_mem_model.sv
dv/tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
